//--- flist.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/cpu_fetch.sv
verilog/cpu_decode.sv
verilog/cpu_registers.sv
verilog/cpu_execute.sv
verilog/cpu_memory.sv
verilog/cpu_core.sv
test/tb_bus_memory.sv
test/tb_cpu_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing -f flist.f --top-module tb_cpu_core -o tb_cpu_core_sim \
	&& ./obj_dir/tb_cpu_core_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "Result: PASSED" sim.log && exit 0 || exit 1

//--- test/tb_cpu_core.sv
`include "cpu_consts.svh"

module tb_cpu_core;

	timeunit 1ns;
	timeprecision 1ps;

	logic        i_clock = 1'b0;
	logic        i_reset;
	logic        ibus_request;
	logic        ibus_ready;
	logic [31:0] ibus_address;
	logic [31:0] ibus_rdata;
	logic        dbus_rw;
	logic        dbus_request;
	logic        dbus_ready;
	logic [31:0] dbus_address;
	logic [31:0] dbus_rdata;
	logic [31:0] dbus_wdata;
	logic [31:0] retire_count;

	// Previous-cycle bus state for the stability checks
	logic        prev_reset;
	logic        prev_ireq;
	logic        prev_iready;
	logic [31:0] prev_iaddr;
	logic        prev_dreq;
	logic        prev_dready;
	logic        prev_drw;
	logic [31:0] prev_daddr;
	logic [31:0] prev_dwdata;
	logic        done;

	logic [31:0] fetch_expect [$];
	logic [31:0] store_addr_expect [$];
	logic [31:0] store_data_expect [$];

	localparam int RETIRED_BEFORE_LOOP = 24;
	localparam logic [31:0] LOOP_PC = `CPU_RESET_PC + 32'd104;

	cpu_core cpu_core_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.o_ibus_request(ibus_request),
		.i_ibus_ready(ibus_ready),
		.o_ibus_address(ibus_address),
		.i_ibus_rdata(ibus_rdata),
		.o_dbus_rw(dbus_rw),
		.o_dbus_request(dbus_request),
		.i_dbus_ready(dbus_ready),
		.o_dbus_address(dbus_address),
		.i_dbus_rdata(dbus_rdata),
		.o_dbus_wdata(dbus_wdata),
		.o_retire_count(retire_count)
	);

	tb_bus_memory mem_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_ibus_request(ibus_request),
		.o_ibus_ready(ibus_ready),
		.i_ibus_address(ibus_address),
		.o_ibus_rdata(ibus_rdata),
		.i_dbus_rw(dbus_rw),
		.i_dbus_request(dbus_request),
		.o_dbus_ready(dbus_ready),
		.i_dbus_address(dbus_address),
		.o_dbus_rdata(dbus_rdata),
		.i_dbus_wdata(dbus_wdata)
	);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string test, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("ERROR: %s expected 0x%08h actual 0x%08h", test, expected, actual);
		stop_run("Check failed");
	endtask

	initial begin
		forever #50 i_clock = ~i_clock;
	end

	// ====================
	// Expected results from the RV32I rules
	initial begin
		for (int i = 0; i <= 21; i++)
			fetch_expect.push_back(`CPU_RESET_PC + 32'(i * 4));
		// BNE skips 88 and JAL skips 96
		fetch_expect.push_back(`CPU_RESET_PC + 32'd92);
		fetch_expect.push_back(`CPU_RESET_PC + 32'd100);
		fetch_expect.push_back(LOOP_PC);
		for (int i = 0; i < 10; i++)
			store_addr_expect.push_back(32'(i * 4));
		store_data_expect = {32'h1234_5000, 32'd93, 32'd107, 32'h1234_5064, 32'd1,
			32'h0000_00F0, 32'h0000_0764, 32'd93, 32'd0, `CPU_RESET_PC + 32'd96};
	end

	// ====================
	// Checks on the falling edge
	always @(negedge i_clock) begin
		if (i_reset || prev_reset) begin
			assert (!ibus_request)
				else report_mismatch("reset ibus request", 0, 32'(ibus_request));
			assert (!dbus_request)
				else report_mismatch("reset dbus request", 0, 32'(dbus_request));
			assert (retire_count == 0) else report_mismatch("reset count", 0, retire_count);
		end
		if (!i_reset && prev_ireq && !prev_iready && ibus_request)
			assert (ibus_address == prev_iaddr)
				else report_mismatch("ibus address hold", prev_iaddr, ibus_address);
		if (!i_reset && prev_dreq && !prev_dready && dbus_request) begin
			assert (dbus_address == prev_daddr)
				else report_mismatch("dbus address hold", prev_daddr, dbus_address);
			assert (dbus_rw == prev_drw)
				else report_mismatch("dbus rw hold", 32'(prev_drw), 32'(dbus_rw));
			assert (dbus_wdata == prev_dwdata)
				else report_mismatch("dbus wdata hold", prev_dwdata, dbus_wdata);
		end
		if (ibus_request && ibus_ready && !done) begin
			if (fetch_expect.size() == 0) begin
				stop_run("Fetch seen after the end of the expected sequence");
			end else begin
				assert (ibus_address == fetch_expect[0])
					else report_mismatch("fetch address", fetch_expect[0], ibus_address);
				void'(fetch_expect.pop_front());
				if (ibus_address == LOOP_PC) begin
					assert (retire_count == RETIRED_BEFORE_LOOP)
						else report_mismatch("retire count", RETIRED_BEFORE_LOOP, retire_count);
					done <= 1'b1;
				end
			end
		end
		if (dbus_request && dbus_ready && dbus_rw) begin
			if (store_addr_expect.size() == 0) begin
				stop_run("Unexpected store on the data bus");
			end else begin
				assert (dbus_address == store_addr_expect[0])
					else report_mismatch("store address", store_addr_expect[0], dbus_address);
				assert (dbus_wdata == store_data_expect[0])
					else report_mismatch("store data", store_data_expect[0], dbus_wdata);
				void'(store_addr_expect.pop_front());
				void'(store_data_expect.pop_front());
			end
		end
		prev_reset  <= i_reset;
		prev_ireq   <= ibus_request;
		prev_iready <= ibus_ready;
		prev_iaddr  <= ibus_address;
		prev_dreq   <= dbus_request;
		prev_dready <= dbus_ready;
		prev_drw    <= dbus_rw;
		prev_daddr  <= dbus_address;
		prev_dwdata <= dbus_wdata;
	end

	// ====================
	// Reset and completion
	initial begin
		int cycles;
		i_reset    = 1'b1;
		prev_reset = 1'b1;
		done       = 1'b0;
		cycles     = 0;
		repeat (2) @(posedge i_clock);
		i_reset <= 1'b0;
		while (!done && cycles < 3000) begin
			@(posedge i_clock);
			cycles++;
		end
		if (!done) begin
			stop_run("Timeout waiting for the program to reach its final loop");
		end else if (store_addr_expect.size() != 0) begin
			stop_run("Program reached its final loop with stores still missing");
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

//--- test/tb_bus_memory.sv
module tb_bus_memory (
	input  logic        i_clock,
	input  logic        i_reset,

	// Read-only instruction bus
	input  logic        i_ibus_request,
	output logic        o_ibus_ready,
	input  logic [31:0] i_ibus_address,
	output logic [31:0] o_ibus_rdata,

	// Data bus
	input  logic        i_dbus_rw,
	input  logic        i_dbus_request,
	output logic        o_dbus_ready,
	input  logic [31:0] i_dbus_address,
	output logic [31:0] o_dbus_rdata,
	input  logic [31:0] i_dbus_wdata
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [31:0] rom [64];
	logic [31:0] ram [64];
	logic [31:0] lcg_state;
	logic [1:0]  ibus_wait;
	logic [1:0]  dbus_wait;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// ====================
	// RV32I encoders
	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	// ====================
	// Program
	initial begin
		o_ibus_ready = 1'b0;
		o_dbus_ready = 1'b0;
		o_ibus_rdata = 32'h0;
		o_dbus_rdata = 32'h0;
		for (int i = 0; i < 64; i++) begin
			rom[i] = 32'h0000_0000;
			// Pattern tied to the word address
			ram[i] = 32'hDA7A_0000 | (i * 4);
		end
		rom[0]  = {20'h12345, 5'd1, 7'h37};
		rom[1]  = enc_i(12'd100, 5'd0, 3'b000, 5'd2, 7'h13);
		rom[2]  = enc_i(12'hFF9, 5'd0, 3'b000, 5'd3, 7'h13);
		rom[3]  = enc_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd4);
		rom[4]  = enc_r(7'h20, 5'd3, 5'd2, 3'b000, 5'd5);
		rom[5]  = enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd6);
		rom[6]  = enc_r(7'h00, 5'd2, 5'd3, 3'b010, 5'd7);
		rom[7]  = enc_i(12'h0F0, 5'd3, 3'b111, 5'd8, 7'h13);
		rom[8]  = enc_i(12'h700, 5'd2, 3'b110, 5'd9, 7'h13);
		rom[9]  = enc_s(12'd0, 5'd1, 5'd0);
		rom[10] = enc_s(12'd4, 5'd4, 5'd0);
		rom[11] = enc_s(12'd8, 5'd5, 5'd0);
		rom[12] = enc_s(12'd12, 5'd6, 5'd0);
		rom[13] = enc_s(12'd16, 5'd7, 5'd0);
		rom[14] = enc_s(12'd20, 5'd8, 5'd0);
		rom[15] = enc_s(12'd24, 5'd9, 5'd0);
		// Load back and store again
		rom[16] = enc_i(12'd4, 5'd0, 3'b010, 5'd10, 7'h03);
		rom[17] = enc_s(12'd28, 5'd10, 5'd0);
		// Write to x0 must be lost
		rom[18] = enc_i(12'd5, 5'd0, 3'b000, 5'd0, 7'h13);
		rom[19] = enc_s(12'd32, 5'd0, 5'd0);
		rom[20] = enc_b(13'd8, 5'd3, 5'd2, 3'b000);
		rom[21] = enc_b(13'd8, 5'd3, 5'd2, 3'b001);
		rom[22] = enc_i(12'd1, 5'd0, 3'b000, 5'd11, 7'h13);
		rom[23] = enc_j(21'd8, 5'd12);
		rom[24] = enc_i(12'd1, 5'd0, 3'b000, 5'd11, 7'h13);
		rom[25] = enc_s(12'd36, 5'd12, 5'd0);
		// Self loop
		rom[26] = enc_j(21'd0, 5'd0);
	end

	// ====================
	// Bus responses with 0 to 3 wait cycles
	always @(posedge i_clock) begin
		if (i_reset) begin
			lcg_state    <= 32'h93328f13;
			ibus_wait    <= 2'd0;
			dbus_wait    <= 2'd1;
			o_ibus_ready <= 1'b0;
			o_dbus_ready <= 1'b0;
			o_ibus_rdata <= 32'h0;
			o_dbus_rdata <= 32'h0;
		end else begin
			o_ibus_ready <= 1'b0;
			o_dbus_ready <= 1'b0;
			lcg_state    <= lcg_next(lcg_state);
			if (i_ibus_request && !o_ibus_ready) begin
				if (ibus_wait == 2'd0) begin
					o_ibus_ready <= 1'b1;
					o_ibus_rdata <= rom[i_ibus_address[7:2]];
					ibus_wait    <= lcg_state[17:16];
				end else begin
					ibus_wait <= ibus_wait - 2'd1;
				end
			end
			if (i_dbus_request && !o_dbus_ready) begin
				if (dbus_wait == 2'd0) begin
					o_dbus_ready <= 1'b1;
					o_dbus_rdata <= ram[i_dbus_address[7:2]];
					if (i_dbus_rw)
						ram[i_dbus_address[7:2]] <= i_dbus_wdata;
					dbus_wait <= lcg_state[25:24];
				end else begin
					dbus_wait <= dbus_wait - 2'd1;
				end
			end
		end
	end

endmodule

//--- verilog/cpu_core.sv
`include "cpu_consts.svh"

module cpu_core (
	input  logic                 i_clock,
	input  logic                 i_reset,

	// Instruction bus
	output logic                 o_ibus_request,
	input  logic                 i_ibus_ready,
	output logic [`CPU_XLEN-1:0] o_ibus_address,
	input  logic [`CPU_XLEN-1:0] i_ibus_rdata,

	// Data bus
	output logic                 o_dbus_rw,
	output logic                 o_dbus_request,
	input  logic                 i_dbus_ready,
	output logic [`CPU_XLEN-1:0] o_dbus_address,
	input  logic [`CPU_XLEN-1:0] i_dbus_rdata,
	output logic [`CPU_XLEN-1:0] o_dbus_wdata,

	// Instructions retired since reset
	output logic [`CPU_XLEN-1:0] o_retire_count
);

	import cpu_pkg::*;

	logic                 fetch_valid;
	logic [`CPU_XLEN-1:0] fetch_instruction;
	logic [`CPU_XLEN-1:0] fetch_pc;

	logic                 decode_valid;
	logic [`CPU_XLEN-1:0] decode_pc;
	logic [4:0]           decode_rd_index;
	logic [`CPU_XLEN-1:0] decode_imm;
	opcode_e              decode_opcode;
	alu_op_e              decode_alu_op;
	logic                 decode_use_imm;
	logic                 decode_reg_write;
	logic                 decode_mem_read;
	logic                 decode_mem_write;
	logic                 decode_branch_ne;

	logic [`CPU_XLEN-1:0] rs1;
	logic [`CPU_XLEN-1:0] rs2;

	logic                 execute_valid;
	logic [4:0]           execute_rd_index;
	logic [`CPU_XLEN-1:0] execute_result;
	logic                 execute_reg_write;
	logic                 execute_mem_read;
	logic                 execute_mem_write;
	logic [`CPU_XLEN-1:0] execute_mem_address;
	logic [`CPU_XLEN-1:0] execute_mem_wdata;
	logic [`CPU_XLEN-1:0] execute_pc_next;

	logic                 memory_retire;
	logic                 memory_reg_write;
	logic [4:0]           memory_rd_index;
	logic [`CPU_XLEN-1:0] memory_rd_value;
	logic [`CPU_XLEN-1:0] memory_pc_next;

	// ====================
	// Fetch and decode
	cpu_fetch fetch_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_retire(memory_retire),
		.i_pc_next(memory_pc_next),
		.o_ibus_request(o_ibus_request),
		.i_ibus_ready(i_ibus_ready),
		.o_ibus_address(o_ibus_address),
		.i_ibus_rdata(i_ibus_rdata),
		.o_valid(fetch_valid),
		.o_instruction(fetch_instruction),
		.o_pc(fetch_pc)
	);

	cpu_decode decode_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_valid(fetch_valid),
		.i_instruction(fetch_instruction),
		.i_pc(fetch_pc),
		.o_valid(decode_valid),
		.o_pc(decode_pc),
		.o_rd_index(decode_rd_index),
		.o_imm(decode_imm),
		.o_opcode(decode_opcode),
		.o_alu_op(decode_alu_op),
		.o_use_imm(decode_use_imm),
		.o_reg_write(decode_reg_write),
		.o_mem_read(decode_mem_read),
		.o_mem_write(decode_mem_write),
		.o_branch_ne(decode_branch_ne)
	);

	// Read in parallel with decode so operands arrive with decode_valid
	cpu_registers registers_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_rs1_index(fetch_instruction[19:15]),
		.i_rs2_index(fetch_instruction[24:20]),
		.o_rs1(rs1),
		.o_rs2(rs2),
		.i_write_enable(memory_reg_write),
		.i_rd_index(memory_rd_index),
		.i_rd_value(memory_rd_value)
	);

	// ====================
	// Execute
	cpu_execute execute_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_valid(decode_valid),
		.i_pc(decode_pc),
		.i_rd_index(decode_rd_index),
		.i_imm(decode_imm),
		.i_opcode(decode_opcode),
		.i_alu_op(decode_alu_op),
		.i_use_imm(decode_use_imm),
		.i_reg_write(decode_reg_write),
		.i_mem_read(decode_mem_read),
		.i_mem_write(decode_mem_write),
		.i_branch_ne(decode_branch_ne),
		.i_rs1(rs1),
		.i_rs2(rs2),
		.o_valid(execute_valid),
		.o_rd_index(execute_rd_index),
		.o_result(execute_result),
		.o_reg_write(execute_reg_write),
		.o_mem_read(execute_mem_read),
		.o_mem_write(execute_mem_write),
		.o_mem_address(execute_mem_address),
		.o_mem_wdata(execute_mem_wdata),
		.o_pc_next(execute_pc_next)
	);

	// ====================
	// Memory and writeback
	cpu_memory memory_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_valid(execute_valid),
		.i_rd_index(execute_rd_index),
		.i_result(execute_result),
		.i_reg_write(execute_reg_write),
		.i_mem_read(execute_mem_read),
		.i_mem_write(execute_mem_write),
		.i_mem_address(execute_mem_address),
		.i_mem_wdata(execute_mem_wdata),
		.i_pc_next(execute_pc_next),
		.o_dbus_rw(o_dbus_rw),
		.o_dbus_request(o_dbus_request),
		.i_dbus_ready(i_dbus_ready),
		.o_dbus_address(o_dbus_address),
		.i_dbus_rdata(i_dbus_rdata),
		.o_dbus_wdata(o_dbus_wdata),
		.o_retire(memory_retire),
		.o_reg_write(memory_reg_write),
		.o_rd_index(memory_rd_index),
		.o_rd_value(memory_rd_value),
		.o_pc_next(memory_pc_next)
	);

	always_ff @(posedge i_clock) begin
		if (i_reset)
			o_retire_count <= '0;
		else if (memory_retire)
			o_retire_count <= o_retire_count + 1'b1;
	end

endmodule

//--- verilog/cpu_memory.sv
`include "cpu_consts.svh"

module cpu_memory (
	input  logic                 i_clock,
	input  logic                 i_reset,

	// From execute
	input  logic                 i_valid,
	input  logic [4:0]           i_rd_index,
	input  logic [`CPU_XLEN-1:0] i_result,
	input  logic                 i_reg_write,
	input  logic                 i_mem_read,
	input  logic                 i_mem_write,
	input  logic [`CPU_XLEN-1:0] i_mem_address,
	input  logic [`CPU_XLEN-1:0] i_mem_wdata,
	input  logic [`CPU_XLEN-1:0] i_pc_next,

	// Data bus, rw high for a write
	output logic                 o_dbus_rw,
	output logic                 o_dbus_request,
	input  logic                 i_dbus_ready,
	output logic [`CPU_XLEN-1:0] o_dbus_address,
	input  logic [`CPU_XLEN-1:0] i_dbus_rdata,
	output logic [`CPU_XLEN-1:0] o_dbus_wdata,

	// Retire and writeback
	output logic                 o_retire,
	output logic                 o_reg_write,
	output logic [4:0]           o_rd_index,
	output logic [`CPU_XLEN-1:0] o_rd_value,
	output logic [`CPU_XLEN-1:0] o_pc_next
);

	import cpu_pkg::*;

	mem_state_e state;
	logic       reg_write_q;

	assign o_retire    = (state == MEM_RETIRE);
	assign o_reg_write = o_retire && reg_write_q;

	// ====================
	// Control
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state          <= MEM_IDLE;
			o_dbus_request <= 1'b0;
		end else begin
			case (state)
				MEM_IDLE: begin
					if (i_valid) begin
						if (i_mem_read || i_mem_write) begin
							o_dbus_request <= 1'b1;
							state          <= MEM_ACCESS;
						end else begin
							state <= MEM_RETIRE;
						end
					end
				end
				MEM_ACCESS: begin
					if (i_dbus_ready) begin
						o_dbus_request <= 1'b0;
						state          <= MEM_RETIRE;
					end
				end
				default: state <= MEM_IDLE;
			endcase
		end
	end

	// ====================
	// Payload
	always_ff @(posedge i_clock) begin
		if (state == MEM_IDLE && i_valid) begin
			o_dbus_rw      <= i_mem_write;
			o_dbus_address <= i_mem_address;
			o_dbus_wdata   <= i_mem_wdata;
			reg_write_q    <= i_reg_write;
			o_rd_index     <= i_rd_index;
			o_rd_value     <= i_result;
			o_pc_next      <= i_pc_next;
		end

		// Load data replaces the execute result
		if (state == MEM_ACCESS && i_dbus_ready && !o_dbus_rw)
			o_rd_value <= i_dbus_rdata;
	end

endmodule

//--- verilog/cpu_execute.sv
`include "cpu_consts.svh"

module cpu_execute (
	input  logic                 i_clock,
	input  logic                 i_reset,

	// From decode
	input  logic                 i_valid,
	input  logic [`CPU_XLEN-1:0] i_pc,
	input  logic [4:0]           i_rd_index,
	input  logic [`CPU_XLEN-1:0] i_imm,
	input  cpu_pkg::opcode_e     i_opcode,
	input  cpu_pkg::alu_op_e     i_alu_op,
	input  logic                 i_use_imm,
	input  logic                 i_reg_write,
	input  logic                 i_mem_read,
	input  logic                 i_mem_write,
	input  logic                 i_branch_ne,

	// Operands from the register file
	input  logic [`CPU_XLEN-1:0] i_rs1,
	input  logic [`CPU_XLEN-1:0] i_rs2,

	// To memory
	output logic                 o_valid,
	output logic [4:0]           o_rd_index,
	output logic [`CPU_XLEN-1:0] o_result,
	output logic                 o_reg_write,
	output logic                 o_mem_read,
	output logic                 o_mem_write,
	output logic [`CPU_XLEN-1:0] o_mem_address,
	output logic [`CPU_XLEN-1:0] o_mem_wdata,
	output logic [`CPU_XLEN-1:0] o_pc_next
);

	import cpu_pkg::*;

	logic [`CPU_XLEN-1:0] operand_b;
	logic [`CPU_XLEN-1:0] alu_result;
	logic [`CPU_XLEN-1:0] pc_plus_4;
	logic [`CPU_XLEN-1:0] pc_target;
	logic                 branch_taken;
	logic                 redirect;

	// ====================
	// ALU
	assign operand_b = i_use_imm ? i_imm : i_rs2;

	always_comb begin
		case (i_alu_op)
			ALU_SUB:    alu_result = i_rs1 - operand_b;
			ALU_AND:    alu_result = i_rs1 & operand_b;
			ALU_OR:     alu_result = i_rs1 | operand_b;
			ALU_XOR:    alu_result = i_rs1 ^ operand_b;
			ALU_SLT:    alu_result = {{(`CPU_XLEN-1){1'b0}},
				($signed(i_rs1) < $signed(operand_b))};
			ALU_PASS_B: alu_result = operand_b;
			default:    alu_result = i_rs1 + operand_b;
		endcase
	end

	// ====================
	// Next PC
	assign pc_plus_4 = i_pc + `CPU_XLEN'd4;
	assign pc_target = i_pc + i_imm;

	// BNE inverts the equality test
	assign branch_taken = (i_rs1 == i_rs2) ^ i_branch_ne;
	assign redirect = (i_opcode == OPC_JAL) || (i_opcode == OPC_BRANCH && branch_taken);

	always_ff @(posedge i_clock) begin
		if (i_reset)
			o_valid <= 1'b0;
		else
			o_valid <= i_valid;
	end

	always_ff @(posedge i_clock) begin
		if (i_valid) begin
			o_rd_index    <= i_rd_index;
			// JAL links the return address
			o_result      <= (i_opcode == OPC_JAL) ? pc_plus_4 : alu_result;
			o_reg_write   <= i_reg_write;
			o_mem_read    <= i_mem_read;
			o_mem_write   <= i_mem_write;
			// Loads and stores run the ALU as rs1 + imm
			o_mem_address <= alu_result;
			o_mem_wdata   <= i_rs2;
			o_pc_next     <= redirect ? pc_target : pc_plus_4;
		end
	end

endmodule

//--- verilog/cpu_registers.sv
`include "cpu_consts.svh"

module cpu_registers (
	input  logic                 i_clock,
	input  logic                 i_reset,

	// Read port, registered
	input  logic [4:0]           i_rs1_index,
	input  logic [4:0]           i_rs2_index,
	output logic [`CPU_XLEN-1:0] o_rs1,
	output logic [`CPU_XLEN-1:0] o_rs2,

	// Write port from the memory stage
	input  logic                 i_write_enable,
	input  logic [4:0]           i_rd_index,
	input  logic [`CPU_XLEN-1:0] i_rd_value
);

	logic [`CPU_XLEN-1:0] regs [`CPU_REG_COUNT];

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++)
				regs[i] <= '0;
		end else if (i_write_enable && i_rd_index != 5'd0) begin
			regs[i_rd_index] <= i_rd_value;
		end
	end

	// x0 reads as zero regardless of array contents
	always_ff @(posedge i_clock) begin
		o_rs1 <= (i_rs1_index == 5'd0) ? '0 : regs[i_rs1_index];
		o_rs2 <= (i_rs2_index == 5'd0) ? '0 : regs[i_rs2_index];
	end

endmodule

//--- verilog/cpu_decode.sv
`include "cpu_consts.svh"

module cpu_decode (
	input  logic                 i_clock,
	input  logic                 i_reset,

	// From fetch
	input  logic                 i_valid,
	input  logic [`CPU_XLEN-1:0] i_instruction,
	input  logic [`CPU_XLEN-1:0] i_pc,

	// To execute
	output logic                 o_valid,
	output logic [`CPU_XLEN-1:0] o_pc,
	output logic [4:0]           o_rd_index,
	output logic [`CPU_XLEN-1:0] o_imm,
	output cpu_pkg::opcode_e     o_opcode,
	output cpu_pkg::alu_op_e     o_alu_op,
	output logic                 o_use_imm,
	output logic                 o_reg_write,
	output logic                 o_mem_read,
	output logic                 o_mem_write,
	output logic                 o_branch_ne
);

	import cpu_pkg::*;

	logic [6:0]           opcode_bits;
	logic [2:0]           funct3;
	logic [6:0]           funct7;

	logic [`CPU_XLEN-1:0] imm_i;
	logic [`CPU_XLEN-1:0] imm_s;
	logic [`CPU_XLEN-1:0] imm_b;
	logic [`CPU_XLEN-1:0] imm_u;
	logic [`CPU_XLEN-1:0] imm_j;

	opcode_e              d_opcode;
	alu_op_e              d_alu_op;
	logic [`CPU_XLEN-1:0] d_imm;
	logic                 d_use_imm;
	logic                 d_reg_write;
	logic                 d_mem_read;
	logic                 d_mem_write;
	logic                 d_branch_ne;
	logic                 alu_funct_ok;

	// Same funct3 encoding for register and immediate forms
	function automatic alu_op_e alu_for_funct3(input logic [2:0] f3);
		case (f3)
			3'b010:  return ALU_SLT;
			3'b100:  return ALU_XOR;
			3'b110:  return ALU_OR;
			3'b111:  return ALU_AND;
			default: return ALU_ADD;
		endcase
	endfunction

	assign opcode_bits = i_instruction[6:0];
	assign funct3      = i_instruction[14:12];
	assign funct7      = i_instruction[31:25];

	// ====================
	// Immediate formats
	assign imm_i = {{20{i_instruction[31]}}, i_instruction[31:20]};
	assign imm_s = {{20{i_instruction[31]}}, i_instruction[31:25], i_instruction[11:7]};
	assign imm_b = {{19{i_instruction[31]}}, i_instruction[31], i_instruction[7],
		i_instruction[30:25], i_instruction[11:8], 1'b0};
	assign imm_u = {i_instruction[31:12], 12'h000};
	assign imm_j = {{11{i_instruction[31]}}, i_instruction[31], i_instruction[19:12],
		i_instruction[20], i_instruction[30:21], 1'b0};

	// ADD, SLT, XOR, OR, AND
	assign alu_funct_ok = (funct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111});

	// ====================
	// Classification
	always_comb begin
		// Anything outside the subset retires as a no-op
		d_opcode    = OPC_ILLEGAL;
		d_alu_op    = ALU_ADD;
		d_imm       = imm_i;
		d_use_imm   = 1'b0;
		d_reg_write = 1'b0;
		d_mem_read  = 1'b0;
		d_mem_write = 1'b0;
		d_branch_ne = 1'b0;

		case (opcode_bits)
			OPC_LUI: begin
				d_opcode    = OPC_LUI;
				d_alu_op    = ALU_PASS_B;
				d_imm       = imm_u;
				d_use_imm   = 1'b1;
				d_reg_write = 1'b1;
			end
			OPC_OP_IMM: begin
				if (alu_funct_ok) begin
					d_opcode    = OPC_OP_IMM;
					d_alu_op    = alu_for_funct3(funct3);
					d_use_imm   = 1'b1;
					d_reg_write = 1'b1;
				end
			end
			OPC_OP: begin
				if (funct7 == 7'b0000000 && alu_funct_ok) begin
					d_opcode    = OPC_OP;
					d_alu_op    = alu_for_funct3(funct3);
					d_reg_write = 1'b1;
				end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
					d_opcode    = OPC_OP;
					d_alu_op    = ALU_SUB;
					d_reg_write = 1'b1;
				end
			end
			OPC_LOAD: begin
				// Word loads only
				if (funct3 == 3'b010) begin
					d_opcode    = OPC_LOAD;
					d_use_imm   = 1'b1;
					d_reg_write = 1'b1;
					d_mem_read  = 1'b1;
				end
			end
			OPC_STORE: begin
				if (funct3 == 3'b010) begin
					d_opcode    = OPC_STORE;
					d_imm       = imm_s;
					d_use_imm   = 1'b1;
					d_mem_write = 1'b1;
				end
			end
			OPC_BRANCH: begin
				// BEQ and BNE
				if (funct3[2:1] == 2'b00) begin
					d_opcode    = OPC_BRANCH;
					d_imm       = imm_b;
					d_branch_ne = funct3[0];
				end
			end
			OPC_JAL: begin
				d_opcode    = OPC_JAL;
				d_imm       = imm_j;
				d_reg_write = 1'b1;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset)
			o_valid <= 1'b0;
		else
			o_valid <= i_valid;
	end

	always_ff @(posedge i_clock) begin
		if (i_valid) begin
			o_pc        <= i_pc;
			o_rd_index  <= i_instruction[11:7];
			o_imm       <= d_imm;
			o_opcode    <= d_opcode;
			o_alu_op    <= d_alu_op;
			o_use_imm   <= d_use_imm;
			o_reg_write <= d_reg_write;
			o_mem_read  <= d_mem_read;
			o_mem_write <= d_mem_write;
			o_branch_ne <= d_branch_ne;
		end
	end

endmodule

//--- verilog/cpu_fetch.sv
`include "cpu_consts.svh"

module cpu_fetch (
	input  logic                 i_clock,
	input  logic                 i_reset,

	// Next PC from the memory stage
	input  logic                 i_retire,
	input  logic [`CPU_XLEN-1:0] i_pc_next,

	// Instruction bus
	output logic                 o_ibus_request,
	input  logic                 i_ibus_ready,
	output logic [`CPU_XLEN-1:0] o_ibus_address,
	input  logic [`CPU_XLEN-1:0] i_ibus_rdata,

	// To decode and register file
	output logic                 o_valid,
	output logic [`CPU_XLEN-1:0] o_instruction,
	output logic [`CPU_XLEN-1:0] o_pc
);

	logic [`CPU_XLEN-1:0] pc;
	// A fetch is owed but not yet requested
	logic                 pending;

	assign o_ibus_address = pc;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			pc             <= `CPU_RESET_PC;
			pending        <= 1'b1;
			o_ibus_request <= 1'b0;
			o_valid        <= 1'b0;
		end else begin
			o_valid <= 1'b0;

			if (i_retire) begin
				pc      <= i_pc_next;
				pending <= 1'b1;
			end

			if (pending && !o_ibus_request) begin
				o_ibus_request <= 1'b1;
				pending        <= 1'b0;
			end else if (o_ibus_request && i_ibus_ready) begin
				o_ibus_request <= 1'b0;
				o_valid        <= 1'b1;
			end
		end
	end

	// Word and its address, held until the next fetch completes
	always_ff @(posedge i_clock) begin
		if (o_ibus_request && i_ibus_ready) begin
			o_instruction <= i_ibus_rdata;
			o_pc          <= pc;
		end
	end

endmodule

//--- verilog/cpu_pkg.sv
package cpu_pkg;

	// ====================
	// Major opcodes, as found in instruction bits 6:0
	typedef enum logic [6:0] {
		OPC_ILLEGAL = 7'b0000000,
		OPC_LOAD    = 7'b0000011,
		OPC_OP_IMM  = 7'b0010011,
		OPC_STORE   = 7'b0100011,
		OPC_OP      = 7'b0110011,
		OPC_LUI     = 7'b0110111,
		OPC_BRANCH  = 7'b1100011,
		OPC_JAL     = 7'b1101111
	} opcode_e;

	// ====================
	// ALU operations
	typedef enum logic [2:0] {
		ALU_ADD    = 3'd0,
		ALU_SUB    = 3'd1,
		ALU_AND    = 3'd2,
		ALU_OR     = 3'd3,
		ALU_XOR    = 3'd4,
		ALU_SLT    = 3'd5,
		// Second operand straight through, used by LUI
		ALU_PASS_B = 3'd6
	} alu_op_e;

	// ====================
	// Memory stage FSM
	typedef enum logic [1:0] {
		// Waiting for execute
		MEM_IDLE   = 2'd0,
		// Data bus request outstanding
		MEM_ACCESS = 2'd1,
		// Retire pulse is high in this state
		MEM_RETIRE = 2'd2
	} mem_state_e;

endpackage

//--- verilog/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// ====================
// Core-wide constants

// Address of the first instruction fetched after reset
`define CPU_RESET_PC 32'h0000_0000

// Architectural registers, x0 included
`define CPU_REG_COUNT 32

// Data and address width
`define CPU_XLEN 32

// ====================

`endif
